// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

    typedef logic [63:0] xlen_t;     // register, alu and memory word
    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SLT    = 4'd7;
    localparam alu_op_t ALU_PASS_B = 4'd8;   // lui

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam instr_t INSTR_EBREAK = 32'h0010_0073;

    localparam pc_t RESET_PC = 32'h0000_0000;

    localparam int DMEM_WORDS = 32;   // doublewords
    localparam int DMEM_IDX_W = 5;

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             stall_i,
    input  logic             ebreak_i,
    output rv_core_pkg::pc_t pc_o,
    output logic             fetch_valid_o,
    output logic             halt_o
);

    rv_core_pkg::pc_t pc_q;
    logic             halted_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q     <= rv_core_pkg::RESET_PC;
            halted_q <= 1'b0;
        end else begin
            if (ebreak_i) begin
                halted_q <= 1'b1;    // sticky until reset
            end
            // freeze on load-use, on ebreak and once halted
            if (!(stall_i || ebreak_i || halted_q)) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    assign pc_o          = pc_q;
    assign fetch_valid_o = !halted_q;    // bubbles into if/id after halt
    assign halt_o        = halted_q;

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  rst_i,
    input  rv_core_pkg::reg_idx_t rs1_i,
    input  rv_core_pkg::reg_idx_t rs2_i,
    input  rv_core_pkg::reg_idx_t rd_i,
    input  logic                  we_i,
    input  rv_core_pkg::xlen_t    wdata_i,
    output rv_core_pkg::xlen_t    rdata1_o,
    output rv_core_pkg::xlen_t    rdata2_o
);

    rv_core_pkg::xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    function automatic rv_core_pkg::xlen_t read_port(input rv_core_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (we_i && idx == rd_i) begin
            return wdata_i;          // same-cycle write passes through
        end
        return regs[idx];
    endfunction

    assign rdata1_o = read_port(rs1_i);
    assign rdata2_o = read_port(rs2_i);

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_i,
    input  rv_core_pkg::instr_t    instr_i,
    input  rv_core_pkg::pc_t       pc_i,
    input  logic                   fetch_valid_i,
    output rv_core_pkg::reg_idx_t  rs1_o,
    output rv_core_pkg::reg_idx_t  rs2_o,
    input  rv_core_pkg::xlen_t     rdata1_i,
    input  rv_core_pkg::xlen_t     rdata2_i,
    input  rv_core_pkg::reg_idx_t  ex_rd_i,
    input  logic                   ex_is_load_i,
    input  rv_core_pkg::xlen_t     ex_result_i,
    input  rv_core_pkg::reg_idx_t  mem_rd_i,
    input  logic                   mem_reg_write_i,
    input  rv_core_pkg::xlen_t     mem_fwd_data_i,
    output logic                   stall_o,
    output logic                   ebreak_o,
    output rv_core_pkg::pc_t       id_pc_o,
    output rv_core_pkg::alu_op_t   id_op_o,
    output rv_core_pkg::xlen_t     id_a_o,
    output rv_core_pkg::xlen_t     id_b_o,
    output rv_core_pkg::xlen_t     id_store_data_o,
    output rv_core_pkg::reg_idx_t  id_rd_o,
    output logic                   id_reg_write_o,
    output logic                   id_is_load_o,
    output logic                   id_is_store_o
);

    rv_core_pkg::instr_t   instr_q;
    rv_core_pkg::pc_t      pc_q;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rv_core_pkg::reg_idx_t rd;
    rv_core_pkg::xlen_t    imm_i;
    rv_core_pkg::xlen_t    imm_s;
    rv_core_pkg::xlen_t    imm_u;
    rv_core_pkg::xlen_t    rs1_val;
    rv_core_pkg::xlen_t    rs2_val;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  writes_rd;

    // if/id register, all-zero word is the bubble
    always_ff @(posedge clk) begin
        if (rst_i) begin
            instr_q <= '0;
        end else if (!stall_o) begin
            instr_q <= (fetch_valid_i && !ebreak_o) ? instr_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            pc_q <= pc_i;
        end
    end

    assign opcode = instr_q[6:0];
    assign rd     = instr_q[11:7];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign rs1_o  = instr_q[19:15];
    assign rs2_o  = instr_q[24:20];
    assign imm_i  = {{52{instr_q[31]}}, instr_q[31:20]};
    assign imm_s  = {{52{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_u  = {{32{instr_q[31]}}, instr_q[31:12], 12'h000};

    // nearest producer wins; ex_rd_i is zero for non-writing instructions
    function automatic rv_core_pkg::xlen_t fwd(input rv_core_pkg::reg_idx_t rs,
                                               input rv_core_pkg::xlen_t rf_val);
        if (rs == '0) begin
            return '0;
        end
        if (rs == ex_rd_i) begin
            return ex_result_i;
        end
        if (mem_reg_write_i && rs == mem_rd_i) begin
            return mem_fwd_data_i;
        end
        return rf_val;               // reg file covers distance three
    endfunction

    assign rs1_val = fwd(rs1_o, rdata1_i);
    assign rs2_val = fwd(rs2_o, rdata2_i);

    always_comb begin
        id_op_o       = rv_core_pkg::ALU_ADD;
        id_b_o        = rs2_val;
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;
        writes_rd     = 1'b0;
        id_is_load_o  = 1'b0;
        id_is_store_o = 1'b0;
        ebreak_o      = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000);
                case (funct3)
                    3'b000: id_op_o = funct7[5] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                    3'b001: id_op_o = rv_core_pkg::ALU_SLL;
                    3'b010: id_op_o = rv_core_pkg::ALU_SLT;
                    3'b100: id_op_o = rv_core_pkg::ALU_XOR;
                    3'b101: id_op_o = rv_core_pkg::ALU_SRL;
                    3'b110: id_op_o = rv_core_pkg::ALU_OR;
                    3'b111: id_op_o = rv_core_pkg::ALU_AND;
                    default: writes_rd = 1'b0;  // sltu
                endcase
            end
            rv_core_pkg::OPC_OP_IMM: begin
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
                id_b_o    = imm_i;
                case (funct3)
                    3'b000: id_op_o = rv_core_pkg::ALU_ADD;
                    3'b100: id_op_o = rv_core_pkg::ALU_XOR;
                    3'b110: id_op_o = rv_core_pkg::ALU_OR;
                    3'b111: id_op_o = rv_core_pkg::ALU_AND;
                    default: writes_rd = 1'b0;  // shifts and slti not decoded
                endcase
            end
            rv_core_pkg::OPC_LOAD: begin
                use_rs1      = 1'b1;
                id_b_o       = imm_i;           // alu forms the address
                id_is_load_o = funct3 == 3'b011;
                writes_rd    = id_is_load_o;
            end
            rv_core_pkg::OPC_STORE: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                id_b_o        = imm_s;
                id_is_store_o = funct3 == 3'b011;
            end
            rv_core_pkg::OPC_LUI: begin
                writes_rd = 1'b1;
                id_op_o   = rv_core_pkg::ALU_PASS_B;
                id_b_o    = imm_u;
            end
            rv_core_pkg::OPC_SYSTEM: begin
                ebreak_o = instr_q == rv_core_pkg::INSTR_EBREAK;
            end
            default: ;                          // bubble
        endcase
    end

    // load in execute feeding this instruction
    assign stall_o = ex_is_load_i && ex_rd_i != '0 &&
                     ((use_rs1 && rs1_o == ex_rd_i) || (use_rs2 && rs2_o == ex_rd_i));

    assign id_reg_write_o  = writes_rd && rd != '0;     // x0 writes dropped here
    assign id_rd_o         = id_reg_write_o ? rd : '0;
    assign id_a_o          = rs1_val;
    assign id_store_data_o = rs2_val;
    assign id_pc_o         = pc_q;

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  rv_core_pkg::pc_t      id_pc_i,
    input  rv_core_pkg::alu_op_t  id_op_i,
    input  rv_core_pkg::xlen_t    id_a_i,
    input  rv_core_pkg::xlen_t    id_b_i,
    input  rv_core_pkg::xlen_t    id_store_data_i,
    input  rv_core_pkg::reg_idx_t id_rd_i,
    input  logic                  id_reg_write_i,
    input  logic                  id_is_load_i,
    input  logic                  id_is_store_i,
    output rv_core_pkg::reg_idx_t ex_rd_o,
    output logic                  ex_is_load_o,
    output logic                  ex_is_store_o,
    output logic                  ex_reg_write_o,
    output rv_core_pkg::xlen_t    ex_result_o,
    output rv_core_pkg::xlen_t    ex_store_data_o,
    output rv_core_pkg::pc_t      ex_pc_o
);

    rv_core_pkg::alu_op_t op_q;
    rv_core_pkg::xlen_t   a_q;
    rv_core_pkg::xlen_t   b_q;

    // id/ex control, a stall turns the slot into a bubble
    always_ff @(posedge clk) begin
        if (rst_i || stall_i) begin
            ex_rd_o        <= '0;
            ex_reg_write_o <= 1'b0;
            ex_is_load_o   <= 1'b0;
            ex_is_store_o  <= 1'b0;
        end else begin
            ex_rd_o        <= id_rd_i;
            ex_reg_write_o <= id_reg_write_i;
            ex_is_load_o   <= id_is_load_i;
            ex_is_store_o  <= id_is_store_i;
        end
    end

    always_ff @(posedge clk) begin
        op_q            <= id_op_i;
        a_q             <= id_a_i;
        b_q             <= id_b_i;
        ex_store_data_o <= id_store_data_i;
        ex_pc_o         <= id_pc_i;
    end

    always_comb begin
        case (op_q)
            rv_core_pkg::ALU_ADD:    ex_result_o = a_q + b_q;   // also ld/sd address
            rv_core_pkg::ALU_SUB:    ex_result_o = a_q - b_q;
            rv_core_pkg::ALU_AND:    ex_result_o = a_q & b_q;
            rv_core_pkg::ALU_OR:     ex_result_o = a_q | b_q;
            rv_core_pkg::ALU_XOR:    ex_result_o = a_q ^ b_q;
            rv_core_pkg::ALU_SLL:    ex_result_o = a_q << b_q[5:0];
            rv_core_pkg::ALU_SRL:    ex_result_o = a_q >> b_q[5:0];
            rv_core_pkg::ALU_SLT:    ex_result_o = {63'd0, ($signed(a_q) < $signed(b_q))};
            rv_core_pkg::ALU_PASS_B: ex_result_o = b_q;
            default:                 ex_result_o = a_q + b_q;
        endcase
    end

endmodule

// ==== hdl/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  rv_core_pkg::reg_idx_t ex_rd_i,
    input  logic                  ex_is_load_i,
    input  logic                  ex_is_store_i,
    input  logic                  ex_reg_write_i,
    input  rv_core_pkg::xlen_t    ex_result_i,
    input  rv_core_pkg::xlen_t    ex_store_data_i,
    input  rv_core_pkg::pc_t      ex_pc_i,
    output rv_core_pkg::reg_idx_t mem_rd_o,
    output logic                  mem_reg_write_o,
    output rv_core_pkg::xlen_t    mem_fwd_data_o,
    output logic                  wb_en_o,
    output rv_core_pkg::reg_idx_t wb_addr_o,
    output rv_core_pkg::xlen_t    wb_data_o,
    output rv_core_pkg::pc_t      wb_pc_o
);

    logic                               is_load_q;
    logic                               is_store_q;
    rv_core_pkg::xlen_t                 result_q;
    rv_core_pkg::xlen_t                 store_data_q;
    rv_core_pkg::pc_t                   pc_q;
    logic [rv_core_pkg::DMEM_IDX_W-1:0] dmem_idx;
    rv_core_pkg::xlen_t                 dmem [rv_core_pkg::DMEM_WORDS];

    // ex/mem register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_rd_o        <= '0;
            mem_reg_write_o <= 1'b0;
            is_load_q       <= 1'b0;
            is_store_q      <= 1'b0;
        end else begin
            mem_rd_o        <= ex_rd_i;
            mem_reg_write_o <= ex_reg_write_i;
            is_load_q       <= ex_is_load_i;
            is_store_q      <= ex_is_store_i;
        end
    end

    always_ff @(posedge clk) begin
        result_q     <= ex_result_i;
        store_data_q <= ex_store_data_i;
        pc_q         <= ex_pc_i;
    end

    assign dmem_idx = result_q[3 +: rv_core_pkg::DMEM_IDX_W];   // address bits 7:3

    always_ff @(posedge clk) begin
        if (is_store_q) begin
            dmem[dmem_idx] <= store_data_q;
        end
    end

    assign mem_fwd_data_o = is_load_q ? dmem[dmem_idx] : result_q;

    // mem/wb register, feeds the reg file write port
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= mem_reg_write_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= mem_rd_o;
        wb_data_o <= mem_fwd_data_o;
        wb_pc_o   <= pc_q;
    end

endmodule

// ==== hdl/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  rv_core_pkg::instr_t   imem_data_i,
    output rv_core_pkg::pc_t      imem_addr_o,
    output logic                  wb_en_o,
    output rv_core_pkg::reg_idx_t wb_addr_o,
    output rv_core_pkg::xlen_t    wb_data_o,
    output rv_core_pkg::pc_t      wb_pc_o,
    output logic                  halt_o
);

    logic                  fetch_valid;
    logic                  stall;
    logic                  ebreak;
    rv_core_pkg::reg_idx_t rs1;
    rv_core_pkg::reg_idx_t rs2;
    rv_core_pkg::xlen_t    rdata1;
    rv_core_pkg::xlen_t    rdata2;
    rv_core_pkg::pc_t      id_pc;
    rv_core_pkg::alu_op_t  id_op;
    rv_core_pkg::xlen_t    id_a;
    rv_core_pkg::xlen_t    id_b;
    rv_core_pkg::xlen_t    id_store_data;
    rv_core_pkg::reg_idx_t id_rd;
    logic                  id_reg_write;
    logic                  id_is_load;
    logic                  id_is_store;
    rv_core_pkg::reg_idx_t ex_rd;
    logic                  ex_is_load;
    logic                  ex_is_store;
    logic                  ex_reg_write;
    rv_core_pkg::xlen_t    ex_result;
    rv_core_pkg::xlen_t    ex_store_data;
    rv_core_pkg::pc_t      ex_pc;
    rv_core_pkg::reg_idx_t mem_rd;
    logic                  mem_reg_write;
    rv_core_pkg::xlen_t    mem_fwd_data;

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_i       (stall),
        .ebreak_i      (ebreak),
        .pc_o          (imem_addr_o),
        .fetch_valid_o (fetch_valid),
        .halt_o        (halt_o)
    );

    decode_stage u_decode (
        .clk             (clk),
        .rst_i           (rst_i),
        .instr_i         (imem_data_i),
        .pc_i            (imem_addr_o),
        .fetch_valid_i   (fetch_valid),
        .rs1_o           (rs1),
        .rs2_o           (rs2),
        .rdata1_i        (rdata1),
        .rdata2_i        (rdata2),
        .ex_rd_i         (ex_rd),
        .ex_is_load_i    (ex_is_load),
        .ex_result_i     (ex_result),
        .mem_rd_i        (mem_rd),
        .mem_reg_write_i (mem_reg_write),
        .mem_fwd_data_i  (mem_fwd_data),
        .stall_o         (stall),
        .ebreak_o        (ebreak),
        .id_pc_o         (id_pc),
        .id_op_o         (id_op),
        .id_a_o          (id_a),
        .id_b_o          (id_b),
        .id_store_data_o (id_store_data),
        .id_rd_o         (id_rd),
        .id_reg_write_o  (id_reg_write),
        .id_is_load_o    (id_is_load),
        .id_is_store_o   (id_is_store)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_i    (rst_i),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rd_i     (wb_addr_o),     // written from mem/wb
        .we_i     (wb_en_o),
        .wdata_i  (wb_data_o),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    execute_stage u_execute (
        .clk             (clk),
        .rst_i           (rst_i),
        .stall_i         (stall),
        .id_pc_i         (id_pc),
        .id_op_i         (id_op),
        .id_a_i          (id_a),
        .id_b_i          (id_b),
        .id_store_data_i (id_store_data),
        .id_rd_i         (id_rd),
        .id_reg_write_i  (id_reg_write),
        .id_is_load_i    (id_is_load),
        .id_is_store_i   (id_is_store),
        .ex_rd_o         (ex_rd),
        .ex_is_load_o    (ex_is_load),
        .ex_is_store_o   (ex_is_store),
        .ex_reg_write_o  (ex_reg_write),
        .ex_result_o     (ex_result),
        .ex_store_data_o (ex_store_data),
        .ex_pc_o         (ex_pc)
    );

    memory_stage u_memory (
        .clk             (clk),
        .rst_i           (rst_i),
        .ex_rd_i         (ex_rd),
        .ex_is_load_i    (ex_is_load),
        .ex_is_store_i   (ex_is_store),
        .ex_reg_write_i  (ex_reg_write),
        .ex_result_i     (ex_result),
        .ex_store_data_i (ex_store_data),
        .ex_pc_i         (ex_pc),
        .mem_rd_o        (mem_rd),
        .mem_reg_write_o (mem_reg_write),
        .mem_fwd_data_o  (mem_fwd_data),
        .wb_en_o         (wb_en_o),
        .wb_addr_o       (wb_addr_o),
        .wb_data_o       (wb_data_o),
        .wb_pc_o         (wb_pc_o)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_o
);

    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_o = 1'b0;             // released between edges
    end

endmodule

// ==== sim/core_asserts.sv ====
`timescale 1ns/1ps

module core_asserts (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  wb_en_i,
    input  rv_core_pkg::reg_idx_t wb_addr_i,
    input  logic                  halt_i,
    input  rv_core_pkg::pc_t      imem_addr_i
);

    no_x0_write: assert property (@(posedge clk) disable iff (rst_i)
        wb_en_i |-> wb_addr_i != '0)
        else $error("writeback strobe with destination x0");

    halt_sticky: assert property (@(posedge clk) disable iff (rst_i)
        halt_i |=> halt_i)
        else $error("halt_o dropped without reset");

    // fetch address frozen once halted
    pc_frozen: assert property (@(posedge clk) disable iff (rst_i)
        halt_i |=> $stable(imem_addr_i))
        else $error("imem_addr_o moved while halted");

endmodule

bind core_top core_asserts u_asserts (
    .clk         (clk),
    .rst_i       (rst_i),
    .wb_en_i     (wb_en_o),
    .wb_addr_i   (wb_addr_o),
    .halt_i      (halt_o),
    .imem_addr_i (imem_addr_o)
);

// ==== sim/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LD     = 7'b0000011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;    // sub
    localparam logic [31:0] NOP_WORD  = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [31:0] EBRK_WORD = 32'h0010_0073;
    localparam int DRAIN_CYCLES       = 8;             // observed after halt

    logic                  clk;
    logic                  rst;
    rv_core_pkg::instr_t   imem_data;
    rv_core_pkg::pc_t      imem_addr;
    logic                  wb_en;
    rv_core_pkg::reg_idx_t wb_addr;
    rv_core_pkg::xlen_t    wb_data;
    rv_core_pkg::pc_t      wb_pc;
    logic                  halt;

    rv_core_pkg::instr_t   prog [$];
    logic [4:0]            exp_rd [$];
    rv_core_pkg::xlen_t    exp_val [$];
    rv_core_pkg::pc_t      exp_pc [$];
    rv_core_pkg::pc_t      halt_pc;
    int                    error_count = 0;
    int                    check_count = 0;

    tb_clock_gen u_clock (
        .clk   (clk),
        .rst_o (rst)
    );

    core_top DUT (
        .clk         (clk),
        .rst_i       (rst),
        .imem_data_i (imem_data),
        .imem_addr_o (imem_addr),
        .wb_en_o     (wb_en),
        .wb_addr_o   (wb_addr),
        .wb_data_o   (wb_data),
        .wb_pc_o     (wb_pc),
        .halt_o      (halt)
    );

    function automatic rv_core_pkg::instr_t reg_op_word(input logic [6:0] funct7,
            input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, OPC_REG};
    endfunction

    function automatic rv_core_pkg::instr_t imm_op_word(input logic [6:0] opcode,
            input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
            input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic rv_core_pkg::instr_t store_word(input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};  // sd
    endfunction

    function automatic rv_core_pkg::instr_t lui_word(input logic [4:0] rd,
            input logic [19:0] upper);
        return {upper, rd, 7'b0110111};
    endfunction

    function automatic rv_core_pkg::instr_t fetch_word(input rv_core_pkg::pc_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return NOP_WORD;              // past the end of the table
    endfunction

    task automatic expect_write(input logic [4:0] rd, input rv_core_pkg::xlen_t value,
                                input rv_core_pkg::pc_t pc);
        exp_rd.push_back(rd);
        exp_val.push_back(value);
        exp_pc.push_back(pc);
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // program and hand-computed writebacks in retirement order
    task automatic load_program();
        prog.push_back(imm_op_word(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'd90));
        prog.push_back(imm_op_word(OPC_IMM, 3'b000, 5'd2, 5'd0, 12'hFFD));    // -3
        prog.push_back(reg_op_word(F7_BASE, 3'b000, 5'd3, 5'd1, 5'd2));       // add
        prog.push_back(reg_op_word(F7_ALT, 3'b000, 5'd4, 5'd3, 5'd1));        // sub
        prog.push_back(reg_op_word(F7_BASE, 3'b111, 5'd5, 5'd4, 5'd1));       // and
        prog.push_back(reg_op_word(F7_BASE, 3'b110, 5'd6, 5'd5, 5'd3));       // or
        prog.push_back(reg_op_word(F7_BASE, 3'b100, 5'd7, 5'd6, 5'd1));       // xor
        prog.push_back(reg_op_word(F7_BASE, 3'b001, 5'd8, 5'd1, 5'd7));       // sll
        prog.push_back(reg_op_word(F7_BASE, 3'b101, 5'd9, 5'd4, 5'd7));       // srl
        prog.push_back(reg_op_word(F7_BASE, 3'b010, 5'd10, 5'd4, 5'd1));      // slt
        prog.push_back(reg_op_word(F7_BASE, 3'b010, 5'd11, 5'd1, 5'd4));
        prog.push_back(imm_op_word(OPC_IMM, 3'b111, 5'd12, 5'd8, 12'h0F0));   // andi
        prog.push_back(imm_op_word(OPC_IMM, 3'b110, 5'd13, 5'd12, 12'h003));  // ori
        prog.push_back(imm_op_word(OPC_IMM, 3'b100, 5'd14, 5'd13, 12'hFFF));  // xori -1
        prog.push_back(lui_word(5'd15, 20'h12345));
        prog.push_back(lui_word(5'd16, 20'h80000));
        prog.push_back(imm_op_word(OPC_IMM, 3'b000, 5'd0, 5'd1, 12'd7));      // to x0
        prog.push_back(reg_op_word(F7_BASE, 3'b000, 5'd17, 5'd0, 5'd15));
        prog.push_back(store_word(5'd0, 5'd15, 12'd16));
        prog.push_back(imm_op_word(OPC_LD, 3'b011, 5'd19, 5'd0, 12'd16));
        prog.push_back(reg_op_word(F7_BASE, 3'b000, 5'd20, 5'd19, 5'd1));     // load-use rs1
        prog.push_back(store_word(5'd12, 5'd16, 12'd0));
        prog.push_back(imm_op_word(OPC_LD, 3'b011, 5'd21, 5'd12, 12'd0));
        prog.push_back(reg_op_word(F7_BASE, 3'b000, 5'd22, 5'd1, 5'd21));     // load-use rs2
        halt_pc = rv_core_pkg::pc_t'(4 * prog.size() + 4);    // fetch stops past ebreak
        prog.push_back(EBRK_WORD);
        prog.push_back(imm_op_word(OPC_IMM, 3'b000, 5'd23, 5'd0, 12'd1));
        prog.push_back(imm_op_word(OPC_IMM, 3'b000, 5'd24, 5'd0, 12'd2));

        expect_write(5'd1, 64'h0000_0000_0000_005A, 32'h00);
        expect_write(5'd2, 64'hFFFF_FFFF_FFFF_FFFD, 32'h04);
        expect_write(5'd3, 64'h0000_0000_0000_0057, 32'h08);
        expect_write(5'd4, 64'hFFFF_FFFF_FFFF_FFFD, 32'h0C);
        expect_write(5'd5, 64'h0000_0000_0000_0058, 32'h10);
        expect_write(5'd6, 64'h0000_0000_0000_005F, 32'h14);
        expect_write(5'd7, 64'h0000_0000_0000_0005, 32'h18);
        expect_write(5'd8, 64'h0000_0000_0000_0B40, 32'h1C);
        expect_write(5'd9, 64'h07FF_FFFF_FFFF_FFFF, 32'h20);
        expect_write(5'd10, 64'h0000_0000_0000_0001, 32'h24);
        expect_write(5'd11, 64'h0000_0000_0000_0000, 32'h28);
        expect_write(5'd12, 64'h0000_0000_0000_0040, 32'h2C);
        expect_write(5'd13, 64'h0000_0000_0000_0043, 32'h30);
        expect_write(5'd14, 64'hFFFF_FFFF_FFFF_FFBC, 32'h34);
        expect_write(5'd15, 64'h0000_0000_1234_5000, 32'h38);
        expect_write(5'd16, 64'hFFFF_FFFF_8000_0000, 32'h3C);
        expect_write(5'd17, 64'h0000_0000_1234_5000, 32'h44);
        expect_write(5'd19, 64'h0000_0000_1234_5000, 32'h4C);
        expect_write(5'd20, 64'h0000_0000_1234_505A, 32'h50);
        expect_write(5'd21, 64'hFFFF_FFFF_8000_0000, 32'h58);
        expect_write(5'd22, 64'hFFFF_FFFF_8000_005A, 32'h5C);
    endtask

    initial begin : drive_imem
        imem_data = NOP_WORD;
        forever begin
            @(negedge clk);
            imem_data = fetch_word(imem_addr);
        end
    end

    initial begin : run_tests
        int exp_idx;
        int halted_cycles;
        load_program();
        @(posedge clk);
        while (rst) begin             // rst only changes on falling edges
            @(negedge clk);
            check_value(64'(wb_en), 64'd0, "wb_en_o in reset");
            check_value(64'(halt), 64'd0, "halt_o in reset");
            check_value(64'(imem_addr), 64'(rv_core_pkg::RESET_PC), "imem_addr_o in reset");
            @(posedge clk);
        end
        exp_idx = 0;
        halted_cycles = 0;
        while (halted_cycles < DRAIN_CYCLES) begin
            @(negedge clk);
            if (wb_en) begin
                if (exp_idx < exp_rd.size()) begin
                    check_value(64'(wb_addr), 64'(exp_rd[exp_idx]), "wb_addr_o");
                    check_value(wb_data, exp_val[exp_idx], "wb_data_o");
                    check_value(64'(wb_pc), 64'(exp_pc[exp_idx]), "wb_pc_o");
                end else begin
                    error_count++;
                    $display("unexpected writeback to x%0d at %0t after the last expected one",
                             wb_addr, $time);
                end
                exp_idx++;
            end
            if (halt) begin
                check_value(64'(imem_addr), 64'(halt_pc), "imem_addr_o while halted");
                halted_cycles++;
            end
        end
        check_value(64'(exp_idx), 64'(exp_rd.size()), "number of writebacks");
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        @(posedge clk);
        limit = (prog.size() + 20) * 10;
        repeat (limit) @(posedge clk);
        $display("timeout: the core did not halt and drain within %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/rv_core_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/core_top.sv
sim/tb_clock_gen.sv
sim/core_asserts.sv
sim/tb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_core \
    -Mdir "$BUILD_DIR" -o tb_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/tb_core" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
